//--- Bender.yml
package:
  name: packet_disaggregate

sources:
  - verilog/packet_pkg.sv
  - verilog/packet_width_converter.sv
  - verilog/packet_demux.sv
  - verilog/packet_disaggregate.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_packet_disaggregate.sv

//--- build.f
+incdir+sim
verilog/packet_pkg.sv
verilog/packet_width_converter.sv
verilog/packet_demux.sv
verilog/packet_disaggregate.sv
sim/tb_packet_disaggregate.sv

//--- sim/tb_packet_model.svh
`ifndef TB_PACKET_MODEL_SVH
`define TB_PACKET_MODEL_SVH

// LCG step, Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Value in 0 .. n-1 from the upper state bits
task automatic draw(inout logic [31:0] s, input int unsigned n, output int unsigned v);
    s = lcg_next(s);
    v = {8'h00, s[31:8]} % n;
endtask

// One wide word, random bytes everywhere, the empty ones too
task automatic make_word(inout logic [31:0] s, input int valid, input logic eop,
                         output pkt_in_word_t w);
    for (int i = 0; i < IN_BYTES / 4; i++) begin
        s = lcg_next(s);
        w.data[i*32 +: 32] = s;
    end
    s = lcg_next(s);
    w.meta = s;
    w.eop  = eop;
    w.mty  = eop ? in_mty_t'(IN_BYTES - valid) : '0;
endtask

// Expected narrow slices of one wide word, lowest lanes first
task automatic add_expected(input pkt_in_word_t w, input int valid, input int port);
    pkt_out_word_t s;
    int            n;
    int            rem;
    n = (valid + OUT_BYTES - 1) / OUT_BYTES;
    for (int i = 0; i < n; i++) begin
        rem    = valid - i * OUT_BYTES;
        s.data = w.data[i*OUT_BYTES*8 +: OUT_BYTES*8];
        s.meta = w.meta;
        s.eop  = w.eop && (i == n - 1);
        s.mty  = (s.eop && rem < OUT_BYTES) ? out_mty_t'(OUT_BYTES - rem) : '0;
        exp_q[port].push_back(s);
        total_slices++;
    end
endtask

`endif

//--- sim/tb_packet_disaggregate.sv
`timescale 1ns/1ps

module tb_packet_disaggregate
    import packet_pkg::*;
();

    localparam logic [31:0] LCG_SEED = 32'ha60ff65a;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    pkt_in_word_t           in_word;
    logic                   in_rdy;
    ctxt_t                  ctxt_sel = '0;
    logic [NUM_OUTPUTS-1:0] out_valid;
    pkt_out_word_t          out_word;
    logic [NUM_OUTPUTS-1:0] out_rdy = '1;
    logic                   event_in;
    logic [NUM_OUTPUTS-1:0] event_out;

    // Reference model state
    pkt_out_word_t exp_q [NUM_OUTPUTS][$];
    int            port_q [$];
    int            routed [NUM_OUTPUTS];
    int            ev_out_cnt [NUM_OUTPUTS];
    int            ev_in_cnt    = 0;
    int            pkts_sent    = 0;
    int            total_slices = 0;
    int            cycle_cnt    = 0;
    logic [31:0]   stim_seed    = LCG_SEED;
    logic [31:0]   gap_seed     = LCG_SEED ^ 32'h5a5a_5a5a;
    logic [31:0]   rdy_seed     = LCG_SEED ^ 32'hc3c3_c3c3;
    logic [31:0]   ctxt_seed    = LCG_SEED ^ 32'h3c3c_3c3c;
    logic          bp_en        = 1'b0;
    logic          at_sop       = 1'b1;
    string         test_name    = "reset";

`include "tb_packet_model.svh"

    packet_disaggregate u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_rdy    (in_rdy),
        .ctxt_sel  (ctxt_sel),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_rdy   (out_rdy),
        .event_in  (event_in),
        .event_out (event_out)
    );

    always #10 clk = ~clk;

    // ========================================
    // Checks
    // ========================================
    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s expected %0h actual %0h", test_name, what,
                     expected, actual);
            stop_run();
        end
    endtask

    task automatic check_idle();
        check_value("in_rdy", 1, in_rdy);
        check_value("out_valid", 0, out_valid);
        check_value("event_in", 0, event_in);
        check_value("event_out", 0, event_out);
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic drive_word(input pkt_in_word_t w);
        logic accepted;
        in_valid = 1'b1;
        in_word  = w;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_rdy;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int len, input int port, input logic gaps);
        pkt_in_word_t w;
        int           nwords;
        int           valid;
        int unsigned  gap;
        nwords = (len + IN_BYTES - 1) / IN_BYTES;
        port_q.push_back(port);
        routed[port]++;
        pkts_sent++;
        for (int i = 0; i < nwords; i++) begin
            valid = (len - i * IN_BYTES < IN_BYTES) ? len - i * IN_BYTES : IN_BYTES;
            make_word(stim_seed, valid, i == nwords - 1, w);
            add_expected(w, valid, port);
            draw(gap_seed, 8, gap);
            if (gaps && gap >= 5) begin
                repeat (gap - 4) begin
                    @(posedge clk);
                    #1;
                end
            end
            drive_word(w);
        end
    endtask

    // Real port while the next slice opens a packet and noise in between
    always @(posedge clk) begin : ctxt_gen
        int unsigned r;
        #1;
        draw(ctxt_seed, 4, r);
        if (at_sop) begin
            ctxt_sel = (port_q.size() != 0) ? ctxt_t'(port_q[0]) : '0;
        end else begin
            ctxt_sel = ctxt_t'(r);
        end
    end

    always @(posedge clk) begin : ready_gen
        int unsigned r;
        #1;
        for (int p = 0; p < NUM_OUTPUTS; p++) begin
            draw(rdy_seed, 4, r);
            out_rdy[p] = !bp_en || (r != 0);
        end
    end

    // ========================================
    // Monitor and watchdog
    // ========================================
    always @(negedge clk) begin : monitor
        pkt_out_word_t          want;
        logic [NUM_OUTPUTS-1:0] want_sel;
        out_data_t              mask;
        int                     port;
        if (rst_n) begin
            ev_in_cnt += int'(event_in);
            for (int p = 0; p < NUM_OUTPUTS; p++) begin
                ev_out_cnt[p] += int'(event_out[p]);
            end
            if (out_valid != '0 && port_q.size() == 0) begin
                $display("slice valid on an output with no packet outstanding");
                stop_run();
            end else if (out_valid != '0) begin
                port           = port_q[0];
                want_sel       = '0;
                want_sel[port] = 1'b1;
                check_value("out_valid", want_sel, out_valid);
                if (out_rdy[port] && exp_q[port].size() == 0) begin
                    $display("more slices than expected on port %0d", port);
                    stop_run();
                end else if (out_rdy[port]) begin
                    want = exp_q[port].pop_front();
                    mask = '0;
                    for (int b = 0; b < OUT_BYTES - int'(want.mty); b++) begin
                        mask[b*8 +: 8] = 8'hff;
                    end
                    check_value("data", want.data & mask, out_word.data & mask);
                    check_value("eop", want.eop, out_word.eop);
                    check_value("mty", want.mty, out_word.mty);
                    check_value("meta", want.meta, out_word.meta);
                    at_sop = want.eop;
                    if (want.eop) begin
                        void'(port_q.pop_front());
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 4 * total_slices + 1000) begin
            $display("timeout after %0d cycles with slices still outstanding", cycle_cnt);
            stop_run();
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin : main
        int unsigned len;
        int unsigned port;
        int          boundary_len [5];
        boundary_len = '{63, 64, 65, 128, 1};
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;

        test_name = "boundary";
        foreach (boundary_len[i]) begin
            send_packet(boundary_len[i], 0, 1'b0);
        end

        // Both passes restart the seed, so they carry the same packets
        for (int pass = 0; pass < 2; pass++) begin
            test_name = (pass == 0) ? "random" : "backpressure";
            bp_en     = (pass == 1);
            stim_seed = LCG_SEED;
            repeat (100) begin
                draw(stim_seed, 448, len);
                draw(stim_seed, NUM_OUTPUTS, port);
                send_packet(64 + len, port, pass == 1);
            end
        end

        // Drain, then let the last event pulse land
        while (port_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        test_name = "events";
        check_value("event_in count", pkts_sent, ev_in_cnt);
        for (int p = 0; p < NUM_OUTPUTS; p++) begin
            check_value("event_out count", routed[p], ev_out_cnt[p]);
            check_value("leftover slices", 0, exp_q[p].size());
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verilog/packet_demux.sv
`timescale 1ns/1ps

module packet_demux
    import packet_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Slices from the converter
    input  logic                   mid_valid,
    input  pkt_out_word_t          mid_word,
    output logic                   mid_rdy,

    // Port select, sampled on the first slice of a packet
    input  ctxt_t                  ctxt_sel,

    // Output ports
    output logic [NUM_OUTPUTS-1:0] out_valid,
    output pkt_out_word_t          out_word,
    input  logic [NUM_OUTPUTS-1:0] out_rdy,

    output logic [NUM_OUTPUTS-1:0] event_out
);

    // ========================================
    // Signals
    // ========================================
    logic                   sop_q;
    ctxt_t                  ctxt_q;
    ctxt_t                  ctxt_cur;
    logic [NUM_OUTPUTS-1:0] sel_onehot;
    logic                   mid_xfer;

    // ========================================
    // Context tracking
    // ========================================

    // First slice uses the live select, the rest use the held copy
    assign ctxt_cur = sop_q ? ctxt_sel : ctxt_q;
    assign mid_xfer = mid_valid && mid_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sop_q  <= 1'b1;
            ctxt_q <= '0;
        end else if (mid_xfer) begin
            sop_q <= mid_word.eop;
            if (sop_q) begin
                ctxt_q <= ctxt_sel;
            end
        end
    end

    // ========================================
    // Routing
    // ========================================
    always_comb begin
        sel_onehot = '0;
        for (int i = 0; i < NUM_OUTPUTS; i++) begin
            if (ctxt_cur == ctxt_t'(i)) begin
                sel_onehot[i] = 1'b1;
            end
        end
    end

    assign out_valid = mid_valid ? sel_onehot : '0;
    assign out_word  = mid_word;

    // Out-of-range context matches no port, so its slices are drained
    assign mid_rdy = (|(sel_onehot & out_rdy)) || (sel_onehot == '0);

    // End of packet per port, one cycle after the eop slice moves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            event_out <= '0;
        end else begin
            event_out <= out_valid & out_rdy & {NUM_OUTPUTS{mid_word.eop}};
        end
    end

endmodule

//--- verilog/packet_disaggregate.sv
`timescale 1ns/1ps

module packet_disaggregate
    import packet_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Wide packet input
    input  logic                   in_valid,
    input  pkt_in_word_t           in_word,
    output logic                   in_rdy,

    input  ctxt_t                  ctxt_sel,

    // Narrow packet outputs, one shared word
    output logic [NUM_OUTPUTS-1:0] out_valid,
    output pkt_out_word_t          out_word,
    input  logic [NUM_OUTPUTS-1:0] out_rdy,

    // End-of-packet pulses
    output logic                   event_in,
    output logic [NUM_OUTPUTS-1:0] event_out
);

    // ========================================
    // Converter to demux
    // ========================================
    logic          mid_valid;
    pkt_out_word_t mid_word;
    logic          mid_rdy;

    packet_width_converter u_converter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_rdy    (in_rdy),
        .mid_valid (mid_valid),
        .mid_word  (mid_word),
        .mid_rdy   (mid_rdy),
        .event_in  (event_in)
    );

    packet_demux u_demux (
        .clk       (clk),
        .rst_n     (rst_n),
        .mid_valid (mid_valid),
        .mid_word  (mid_word),
        .mid_rdy   (mid_rdy),
        .ctxt_sel  (ctxt_sel),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_rdy   (out_rdy),
        .event_out (event_out)
    );

endmodule

//--- verilog/packet_pkg.sv
package packet_pkg;

    // ========================================
    // Sizing
    // ========================================

    // Output ports on the narrow side
    localparam int NUM_OUTPUTS = 3;

    // Bus widths in bytes
    localparam int IN_BYTES  = 64;
    localparam int OUT_BYTES = 16;

    // Narrow slices carved out of one wide word
    localparam int SLICES_PER_WORD = IN_BYTES / OUT_BYTES;

    localparam int META_WID = 32;

    // Derived field widths
    localparam int IN_MTY_WID    = $clog2(IN_BYTES);
    localparam int OUT_MTY_WID   = $clog2(OUT_BYTES);
    localparam int CTXT_WID      = $clog2(NUM_OUTPUTS);
    localparam int SLICE_IDX_WID = $clog2(SLICES_PER_WORD);

    // ========================================
    // Vector types
    // ========================================

    // Byte 0 of a word sits in bits [7:0]
    typedef logic [IN_BYTES*8-1:0]  in_data_t;
    typedef logic [OUT_BYTES*8-1:0] out_data_t;

    // Empty byte count at the high end of the word
    typedef logic [IN_MTY_WID-1:0]  in_mty_t;
    typedef logic [OUT_MTY_WID-1:0] out_mty_t;

    typedef logic [META_WID-1:0] meta_t;

    // Output port index
    typedef logic [CTXT_WID-1:0] ctxt_t;

    // Slice position inside a wide word
    typedef logic [SLICE_IDX_WID-1:0] slice_idx_t;

    // ========================================
    // Word structs
    // ========================================

    typedef struct packed {
        in_data_t data;
        logic     eop;
        in_mty_t  mty;
        meta_t    meta;
    } pkt_in_word_t;

    typedef struct packed {
        out_data_t data;
        logic      eop;
        out_mty_t  mty;
        meta_t     meta;
    } pkt_out_word_t;

    // Width converter FSM
    typedef enum logic {
        IDLE,
        SLICING
    } conv_state_t;

endpackage

//--- verilog/packet_width_converter.sv
`timescale 1ns/1ps

module packet_width_converter
    import packet_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // Wide input
    input  logic          in_valid,
    input  pkt_in_word_t  in_word,
    output logic          in_rdy,

    // Narrow output toward the demux
    output logic          mid_valid,
    output pkt_out_word_t mid_word,
    input  logic          mid_rdy,

    // End of packet seen on the input
    output logic          event_in
);

    // ========================================
    // Signals
    // ========================================
    conv_state_t  state;
    conv_state_t  state_nxt;

    pkt_in_word_t word_q;
    slice_idx_t   slice_idx;
    slice_idx_t   last_idx;
    slice_idx_t   last_idx_in;

    logic         in_xfer;
    logic         mid_xfer;
    logic         slice_last;

    // ========================================
    // Handshakes
    // ========================================
    assign slice_last = (slice_idx == last_idx);
    assign mid_xfer   = mid_valid && mid_rdy;

    // Accept the next word while the final slice of the current one moves
    assign in_rdy  = (state == IDLE) || (mid_xfer && slice_last);
    assign in_xfer = in_valid && in_rdy;

    // Index of the final slice, from the valid bytes of an eop word
    always_comb begin
        if (in_word.eop) begin
            last_idx_in = slice_idx_t'((IN_BYTES - 1 - int'(in_word.mty)) / OUT_BYTES);
        end else begin
            last_idx_in = slice_idx_t'(SLICES_PER_WORD - 1);
        end
    end

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_xfer) begin
                    state_nxt = SLICING;
                end
            end
            SLICING: begin
                // A new word may replace the old one in the same cycle
                if (mid_xfer && slice_last && !in_xfer) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            slice_idx <= '0;
            last_idx  <= '0;
            event_in  <= 1'b0;
        end else begin
            state    <= state_nxt;
            event_in <= in_xfer && in_word.eop;
            if (in_xfer) begin
                slice_idx <= '0;
                last_idx  <= last_idx_in;
            end else if (mid_xfer) begin
                slice_idx <= slice_idx + 1'b1;
            end
        end
    end

    // Held wide word
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            word_q <= in_word;
        end
    end

    // ========================================
    // Slice output
    // ========================================
    assign mid_valid = (state == SLICING);

    always_comb begin
        mid_word.data = word_q.data[int'(slice_idx)*OUT_BYTES*8 +: OUT_BYTES*8];
        mid_word.meta = word_q.meta;
        mid_word.eop  = word_q.eop && slice_last;
        // Leftover empty bytes land in the final slice
        if (mid_word.eop) begin
            mid_word.mty = out_mty_t'(word_q.mty % OUT_BYTES);
        end else begin
            mid_word.mty = '0;
        end
    end

endmodule
